// ==== project.f ====
verilog/vrf_pkg.sv
verilog/opreq_pkg.sv
verilog/operand_fetch.sv
verilog/writeback_router.sv
verilog/vrf_arbiter.sv
verilog/opreq_top.sv
sim/opreq_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the operand fetch testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal -j 0 --top-module opreq_tb -f project.f \
  && ./obj_dir/Vopreq_tb > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "TEST FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; } || true
grep -q "TEST OK" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0

// ==== sim/opreq_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Directed testbench for the operand fetch and VRF arbitration stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module opreq_tb;

  import vrf_pkg::*;
  import opreq_pkg::*;

  localparam int unsigned TbVlen = 256;
  localparam int ResetCycles    = 16;
  localparam int NumTests       = 6;
  localparam int CyclesPerTest  = 664;
  localparam int WatchdogCycles = ResetCycles + NumTests * CyclesPerTest;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             qa_req_valid_i;
  logic                             qa_req_ready_o;
  vreg_idx_t                        qa_req_vs_i;
  vlen_t                            qa_req_vstart_i;
  vlen_t                            qa_req_vl_i;
  eew_e                             qa_req_eew_i;
  logic                             qb_req_valid_i;
  logic                             qb_req_ready_o;
  vreg_idx_t                        qb_req_vs_i;
  vlen_t                            qb_req_vstart_i;
  vlen_t                            qb_req_vl_i;
  eew_e                             qb_req_eew_i;
  logic                             qa_queue_ready_i;
  logic                             qb_queue_ready_i;
  logic                             qa_issued_o;
  logic                             qb_issued_o;
  logic                             alu_req_i;
  vaddr_t                           alu_addr_i;
  vrf_word_t                        alu_wdata_i;
  vrf_strb_t                        alu_be_i;
  logic                             alu_gnt_o;
  logic                             ldu_req_i;
  vaddr_t                           ldu_addr_i;
  vrf_word_t                        ldu_wdata_i;
  vrf_strb_t                        ldu_be_i;
  logic                             ldu_gnt_o;
  logic [NrBanks-1:0]               vrf_req_o;
  logic [NrBanks-1:0]               vrf_wen_o;
  logic [NrBanks-1:0][RowW-1:0]     vrf_row_o;
  vrf_word_t [NrBanks-1:0]          vrf_wdata_o;
  vrf_strb_t [NrBanks-1:0]          vrf_be_o;
  vrf_tgt_e  [NrBanks-1:0]          vrf_tgt_o;

  string test_name;
  int    seed;

  opreq_top #(.VLEN(TbVlen)) i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////
  // Reference model and reporting
  ////////////////////////////////////////////////////////////////////

  // First word is vs times words per register plus the whole words skipped by vstart
  function automatic int first_word(int vs, int vstart, eew_e eew);
    int epw;
    epw = 8 >> int'(eew);
    return vs * (TbVlen / 64) + vstart / epw;
  endfunction

  function automatic int word_count(int vstart, int vl, eew_e eew);
    int epw;
    epw = 8 >> int'(eew);
    if (vl <= vstart) return 0;
    return (vl - vstart + epw - 1) / epw;
  endfunction

  // Words interleave over the banks
  function automatic void locate_word(input int word, output int bank, output int row);
    bank = word % NrBanks;
    row  = word / NrBanks;
  endfunction

  // Number of banks currently carrying a read for this queue
  function automatic int tgt_hits(vrf_tgt_e tgt);
    int n;
    n = 0;
    for (int b = 0; b < NrBanks; b++) begin
      if (vrf_req_o[b] && !vrf_wen_o[b] && vrf_tgt_o[b] == tgt) n++;
    end
    return n;
  endfunction

  task automatic mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("CHECK FAILED %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic abort_run(input string msg);
    $display("Error in %s: %s", test_name, msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////

  task automatic init_inputs();
    rst_ni           <= 1'b0;
    qa_req_valid_i   <= 1'b0;
    qa_req_vs_i      <= '0;
    qa_req_vstart_i  <= '0;
    qa_req_vl_i      <= '0;
    qa_req_eew_i     <= EW8;
    qb_req_valid_i   <= 1'b0;
    qb_req_vs_i      <= '0;
    qb_req_vstart_i  <= '0;
    qb_req_vl_i      <= '0;
    qb_req_eew_i     <= EW8;
    qa_queue_ready_i <= 1'b1;
    qb_queue_ready_i <= 1'b1;
    alu_req_i        <= 1'b0;
    alu_addr_i       <= '0;
    alu_wdata_i      <= '0;
    alu_be_i         <= '0;
    ldu_req_i        <= 1'b0;
    ldu_addr_i       <= '0;
    ldu_wdata_i      <= '0;
    ldu_be_i         <= '0;
  endtask

  task automatic apply_reset();
    test_name = "reset";
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (vrf_req_o == '0) else mismatch("vrf_req_o", 0, vrf_req_o);
    assert (!qa_issued_o && !qb_issued_o) else abort_run("issued pulse out of reset");
    assert (!alu_gnt_o) else mismatch("alu_gnt_o", 0, alu_gnt_o);
    assert (ldu_gnt_o) else mismatch("ldu_gnt_o", 1, ldu_gnt_o);
  endtask

  // Returns right after the edge that accepts the request
  task automatic drive_req(input vrf_tgt_e q, input int vs, input int vstart, input int vl,
                           input eew_e eew);
    @(posedge clk_i);
    if (q == TGT_QA) begin
      qa_req_valid_i  <= 1'b1;
      qa_req_vs_i     <= vreg_idx_t'(vs);
      qa_req_vstart_i <= vlen_t'(vstart);
      qa_req_vl_i     <= vlen_t'(vl);
      qa_req_eew_i    <= eew;
    end else begin
      qb_req_valid_i  <= 1'b1;
      qb_req_vs_i     <= vreg_idx_t'(vs);
      qb_req_vstart_i <= vlen_t'(vstart);
      qb_req_vl_i     <= vlen_t'(vl);
      qb_req_eew_i    <= eew;
    end
    do @(negedge clk_i); while (!((q == TGT_QA) ? qa_req_ready_o : qb_req_ready_o));
    @(posedge clk_i);
    qa_req_valid_i <= 1'b0;
    qb_req_valid_i <= 1'b0;
  endtask

  // Holds the queue not ready for a few cycles and checks that nothing is read
  task automatic hold_queue(input vrf_tgt_e tgt, input int cycles);
    @(posedge clk_i);
    if (tgt == TGT_QA) qa_queue_ready_i <= 1'b0;
    else qb_queue_ready_i <= 1'b0;
    repeat (cycles) begin
      @(negedge clk_i);
      assert (tgt_hits(tgt) == 0) else abort_run("read reached the VRF while the queue was full");
      assert (!((tgt == TGT_QA) ? qa_issued_o : qb_issued_o))
        else abort_run("issued pulse while the queue was full");
    end
    @(posedge clk_i);
    qa_queue_ready_i <= 1'b1;
    qb_queue_ready_i <= 1'b1;
  endtask

  // Follows the reads of one operand, word by word, then checks for stray pulses
  task automatic check_reads(input vrf_tgt_e tgt, input int word0, input int nwords,
                             input int pause_after);
    int   got;
    int   bank;
    int   row;
    logic issued;
    got = 0;
    while (got < nwords) begin
      @(negedge clk_i);
      issued = (tgt == TGT_QA) ? qa_issued_o : qb_issued_o;
      if (issued) begin
        locate_word(word0 + got, bank, row);
        assert (tgt_hits(tgt) == 1) else mismatch("banks reading", 1, tgt_hits(tgt));
        assert (vrf_req_o[bank]) else mismatch("bank request", 1 << bank, vrf_req_o);
        assert (!vrf_wen_o[bank]) else mismatch("write enable", 0, vrf_wen_o[bank]);
        assert (vrf_row_o[bank] == row) else mismatch("row", row, vrf_row_o[bank]);
        assert (vrf_tgt_o[bank] == tgt) else mismatch("target", tgt, vrf_tgt_o[bank]);
        got++;
        if (got == pause_after) hold_queue(tgt, 4);
      end else begin
        assert (tgt_hits(tgt) == 0) else abort_run("read without an issued pulse");
      end
    end
    repeat (4) begin
      @(negedge clk_i);
      issued = (tgt == TGT_QA) ? qa_issued_o : qb_issued_o;
      assert (!issued) else abort_run("issued pulse after the last word");
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////

  task automatic test_read_walk();
    test_name = "read_walk";
    drive_req(TGT_QA, 2, 0, 10, EW16);
    check_reads(TGT_QA, first_word(2, 0, EW16), word_count(0, 10, EW16), -1);
  endtask

  task automatic test_offset_and_empty();
    test_name = "vstart_offset";
    drive_req(TGT_QB, 1, 9, 20, EW8);
    check_reads(TGT_QB, first_word(1, 9, EW8), word_count(9, 20, EW8), -1);
    test_name = "empty_request";
    drive_req(TGT_QB, 1, 12, 12, EW8);
    repeat (8) begin
      @(negedge clk_i);
      assert (!qb_issued_o && tgt_hits(TGT_QB) == 0) else abort_run("empty request was read");
      assert (qb_req_ready_o) else mismatch("qb_req_ready_o", 1, qb_req_ready_o);
    end
  endtask

  task automatic test_alu_write();
    logic [9:0] addr;
    vrf_word_t  data;
    vrf_strb_t  be;
    int         bank;
    int         row;
    test_name = "alu_write";
    addr = 10'($random(seed));
    data = {$random(seed), $random(seed)};
    be   = 8'($random(seed));
    locate_word(int'(addr), bank, row);
    @(posedge clk_i);
    alu_req_i   <= 1'b1;
    alu_addr_i  <= addr;
    alu_wdata_i <= data;
    alu_be_i    <= be;
    do @(negedge clk_i); while (!alu_gnt_o);
    assert (vrf_req_o[bank] && vrf_wen_o[bank]) else mismatch("write banks", 1 << bank, vrf_wen_o);
    assert (vrf_row_o[bank] == row) else mismatch("row", row, vrf_row_o[bank]);
    assert (vrf_wdata_o[bank] == data) else mismatch("data", data, vrf_wdata_o[bank]);
    assert (vrf_be_o[bank] == be) else mismatch("byte enable", be, vrf_be_o[bank]);
    assert (vrf_tgt_o[bank] == TGT_NONE) else mismatch("target", TGT_NONE, vrf_tgt_o[bank]);
    @(posedge clk_i);
    alu_req_i <= 1'b0;
  endtask

  task automatic test_load_write();
    logic [9:0] addr [2];
    vrf_word_t  data [2];
    vrf_strb_t  be [2];
    int         sent;
    int         written;
    int         hits;
    int         bank;
    int         exp_bank;
    int         exp_row;
    logic       handshake;
    test_name = "load_write";
    for (int i = 0; i < 2; i++) begin
      addr[i] = 10'($random(seed));
      data[i] = {$random(seed), $random(seed)};
      be[i]   = 8'($random(seed));
    end
    sent    = 0;
    written = 0;
    bank    = 0;
    @(posedge clk_i);
    ldu_req_i   <= 1'b1;
    ldu_addr_i  <= addr[0];
    ldu_wdata_i <= data[0];
    ldu_be_i    <= be[0];
    while (written < 2) begin
      @(negedge clk_i);
      hits = 0;
      for (int b = 0; b < NrBanks; b++) begin
        if (vrf_req_o[b] && vrf_wen_o[b]) begin
          hits++;
          bank = b;
        end
      end
      if (hits != 0) begin
        assert (hits == 1) else mismatch("writing banks", 1, hits);
        // Sent only counts entries whose accepting edge has passed
        assert (written < sent) else abort_run("load write reached the VRF in its acceptance cycle");
        locate_word(int'(addr[written]), exp_bank, exp_row);
        assert (bank == exp_bank) else mismatch("bank", exp_bank, bank);
        assert (vrf_row_o[bank] == exp_row) else mismatch("row", exp_row, vrf_row_o[bank]);
        assert (vrf_wdata_o[bank] == data[written])
          else mismatch("data", data[written], vrf_wdata_o[bank]);
        assert (vrf_be_o[bank] == be[written])
          else mismatch("byte enable", be[written], vrf_be_o[bank]);
        written++;
      end
      handshake = ldu_req_i && ldu_gnt_o;
      @(posedge clk_i);
      if (handshake) begin
        sent++;
        if (sent < 2) begin
          ldu_addr_i  <= addr[sent];
          ldu_wdata_i <= data[sent];
          ldu_be_i    <= be[sent];
        end else begin
          ldu_req_i <= 1'b0;
        end
      end
    end
  endtask

  task automatic test_priority();
    logic a;
    logic w;
    logic prev_a;
    logic started;
    int   grants;
    // ALU at word 20 sits on bank 0, as does word 0 of queue B
    test_name = "group_priority";
    drive_req(TGT_QB, 0, 0, 8, EW8);
    alu_req_i   <= 1'b1;
    alu_addr_i  <= 10'd20;
    alu_wdata_i <= {$random(seed), $random(seed)};
    alu_be_i    <= 8'hff;
    repeat (3) begin
      @(negedge clk_i);
      assert (alu_gnt_o) else mismatch("alu_gnt_o", 1, alu_gnt_o);
      assert (!qb_issued_o) else abort_run("queue B won bank 0 against the ALU");
      assert (vrf_wen_o[0]) else mismatch("bank 0 write enable", 1, vrf_wen_o[0]);
    end
    @(posedge clk_i);
    alu_req_i <= 1'b0;
    check_reads(TGT_QB, first_word(0, 0, EW8), word_count(0, 8, EW8), -1);

    // Single-word operands back to back keep queue A on bank 0 every cycle
    test_name = "round_robin";
    started = 1'b0;
    prev_a  = 1'b0;
    grants  = 0;
    @(posedge clk_i);
    qa_req_valid_i  <= 1'b1;
    qa_req_vs_i     <= '0;
    qa_req_vstart_i <= '0;
    qa_req_vl_i     <= vlen_t'(1);
    qa_req_eew_i    <= EW64;
    alu_req_i       <= 1'b1;
    alu_addr_i      <= '0;
    repeat (12) begin
      @(negedge clk_i);
      a = qa_issued_o;
      w = alu_gnt_o;
      assert (!(a && w)) else abort_run("queue A and the ALU granted together");
      if (started) begin
        assert (a != w) else abort_run("bank 0 idle while both requested");
        assert (a != prev_a) else mismatch("queue A grant", !prev_a, a);
        grants++;
      end
      if (a) started = 1'b1;
      prev_a = a;
    end
    assert (grants >= 8) else mismatch("contended cycles", 8, grants);
    @(posedge clk_i);
    qa_req_valid_i <= 1'b0;
    alu_req_i      <= 1'b0;
    do @(negedge clk_i); while (!qa_req_ready_o || qa_issued_o);
  endtask

  task automatic test_back_pressure();
    test_name = "back_pressure";
    drive_req(TGT_QA, 3, 0, 32, EW8);
    check_reads(TGT_QA, first_word(3, 0, EW8), word_count(0, 32, EW8), 2);
  endtask

  initial begin
    seed = 64776;
    init_inputs();
    apply_reset();
    test_read_walk();
    test_offset_and_empty();
    test_alu_write();
    test_load_write();
    test_priority();
    test_back_pressure();
    $display("TEST OK");
    $finish;
  end

  // Budget covers reset plus a generous share per test
  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout after %0d cycles in %s, DUT stopped responding", WatchdogCycles, test_name);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule : opreq_tb

// ==== verilog/opreq_top.sv ====
//////////////////////////////////////////////////////////////////////
// Operand fetch and VRF arbitration stage of a one-lane vector unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module opreq_top #(
  parameter int unsigned VLEN = 256
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  // Queue A request
  input  logic                                           qa_req_valid_i,
  output logic                                           qa_req_ready_o,
  input  opreq_pkg::vreg_idx_t                           qa_req_vs_i,
  input  opreq_pkg::vlen_t                               qa_req_vstart_i,
  input  opreq_pkg::vlen_t                               qa_req_vl_i,
  input  opreq_pkg::eew_e                                qa_req_eew_i,
  // Queue B request
  input  logic                                           qb_req_valid_i,
  output logic                                           qb_req_ready_o,
  input  opreq_pkg::vreg_idx_t                           qb_req_vs_i,
  input  opreq_pkg::vlen_t                               qb_req_vstart_i,
  input  opreq_pkg::vlen_t                               qb_req_vl_i,
  input  opreq_pkg::eew_e                                qb_req_eew_i,
  // Operand queues
  input  logic                                           qa_queue_ready_i,
  input  logic                                           qb_queue_ready_i,
  output logic                                           qa_issued_o,
  output logic                                           qb_issued_o,
  // Write-back ports
  input  logic                                           alu_req_i,
  input  vrf_pkg::vaddr_t                                alu_addr_i,
  input  vrf_pkg::vrf_word_t                             alu_wdata_i,
  input  vrf_pkg::vrf_strb_t                             alu_be_i,
  output logic                                           alu_gnt_o,
  input  logic                                           ldu_req_i,
  input  vrf_pkg::vaddr_t                                ldu_addr_i,
  input  vrf_pkg::vrf_word_t                             ldu_wdata_i,
  input  vrf_pkg::vrf_strb_t                             ldu_be_i,
  output logic                                           ldu_gnt_o,
  // VRF banks
  output logic [vrf_pkg::NrBanks-1:0]                    vrf_req_o,
  output logic [vrf_pkg::NrBanks-1:0]                    vrf_wen_o,
  output logic [vrf_pkg::NrBanks-1:0][vrf_pkg::RowW-1:0] vrf_row_o,
  output vrf_pkg::vrf_word_t [vrf_pkg::NrBanks-1:0]      vrf_wdata_o,
  output vrf_pkg::vrf_strb_t [vrf_pkg::NrBanks-1:0]      vrf_be_o,
  output vrf_pkg::vrf_tgt_e  [vrf_pkg::NrBanks-1:0]      vrf_tgt_o
);

  import vrf_pkg::*;

  logic [NrBanks-1:0] qa_bank_req, qb_bank_req, alu_bank_req, ldu_bank_req;
  logic [NrBanks-1:0] qa_bank_gnt, qb_bank_gnt, alu_bank_gnt, ldu_bank_gnt;
  logic [RowW-1:0]    qa_row, qb_row, alu_row, ldu_row;
  vrf_word_t          alu_wdata, ldu_wdata;
  vrf_strb_t          alu_be, ldu_be;

  operand_fetch #(.VLEN(VLEN)) i_fetch_qa (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (qa_req_valid_i),
    .req_ready_o  (qa_req_ready_o),
    .req_vs_i     (qa_req_vs_i),
    .req_vstart_i (qa_req_vstart_i),
    .req_vl_i     (qa_req_vl_i),
    .req_eew_i    (qa_req_eew_i),
    .queue_ready_i(qa_queue_ready_i),
    .issued_o     (qa_issued_o),
    .bank_req_o   (qa_bank_req),
    .bank_row_o   (qa_row),
    .bank_gnt_i   (qa_bank_gnt)
  );

  operand_fetch #(.VLEN(VLEN)) i_fetch_qb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (qb_req_valid_i),
    .req_ready_o  (qb_req_ready_o),
    .req_vs_i     (qb_req_vs_i),
    .req_vstart_i (qb_req_vstart_i),
    .req_vl_i     (qb_req_vl_i),
    .req_eew_i    (qb_req_eew_i),
    .queue_ready_i(qb_queue_ready_i),
    .issued_o     (qb_issued_o),
    .bank_req_o   (qb_bank_req),
    .bank_row_o   (qb_row),
    .bank_gnt_i   (qb_bank_gnt)
  );

  writeback_router i_wb_router (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .alu_req_i     (alu_req_i),
    .alu_addr_i    (alu_addr_i),
    .alu_wdata_i   (alu_wdata_i),
    .alu_be_i      (alu_be_i),
    .alu_gnt_o     (alu_gnt_o),
    .ldu_req_i     (ldu_req_i),
    .ldu_addr_i    (ldu_addr_i),
    .ldu_wdata_i   (ldu_wdata_i),
    .ldu_be_i      (ldu_be_i),
    .ldu_gnt_o     (ldu_gnt_o),
    .alu_bank_req_o(alu_bank_req),
    .ldu_bank_req_o(ldu_bank_req),
    .alu_row_o     (alu_row),
    .ldu_row_o     (ldu_row),
    .alu_wdata_o   (alu_wdata),
    .alu_be_o      (alu_be),
    .ldu_wdata_o   (ldu_wdata),
    .ldu_be_o      (ldu_be),
    .alu_bank_gnt_i(alu_bank_gnt),
    .ldu_bank_gnt_i(ldu_bank_gnt)
  );

  vrf_arbiter i_vrf_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .qa_bank_req_i (qa_bank_req),
    .qb_bank_req_i (qb_bank_req),
    .alu_bank_req_i(alu_bank_req),
    .ldu_bank_req_i(ldu_bank_req),
    .qa_row_i      (qa_row),
    .qb_row_i      (qb_row),
    .alu_row_i     (alu_row),
    .ldu_row_i     (ldu_row),
    .alu_wdata_i   (alu_wdata),
    .ldu_wdata_i   (ldu_wdata),
    .alu_be_i      (alu_be),
    .ldu_be_i      (ldu_be),
    .qa_bank_gnt_o (qa_bank_gnt),
    .qb_bank_gnt_o (qb_bank_gnt),
    .alu_bank_gnt_o(alu_bank_gnt),
    .ldu_bank_gnt_o(ldu_bank_gnt),
    .vrf_req_o     (vrf_req_o),
    .vrf_wen_o     (vrf_wen_o),
    .vrf_row_o     (vrf_row_o),
    .vrf_wdata_o   (vrf_wdata_o),
    .vrf_be_o      (vrf_be_o),
    .vrf_tgt_o     (vrf_tgt_o)
  );

endmodule : opreq_top

// ==== verilog/vrf_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// Per-bank VRF arbiter: fixed group priority, round-robin inside
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vrf_arbiter (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  // Bank requests
  input  logic [vrf_pkg::NrBanks-1:0]                    qa_bank_req_i,
  input  logic [vrf_pkg::NrBanks-1:0]                    qb_bank_req_i,
  input  logic [vrf_pkg::NrBanks-1:0]                    alu_bank_req_i,
  input  logic [vrf_pkg::NrBanks-1:0]                    ldu_bank_req_i,
  input  logic [vrf_pkg::RowW-1:0]                       qa_row_i,
  input  logic [vrf_pkg::RowW-1:0]                       qb_row_i,
  input  logic [vrf_pkg::RowW-1:0]                       alu_row_i,
  input  logic [vrf_pkg::RowW-1:0]                       ldu_row_i,
  input  vrf_pkg::vrf_word_t                             alu_wdata_i,
  input  vrf_pkg::vrf_word_t                             ldu_wdata_i,
  input  vrf_pkg::vrf_strb_t                             alu_be_i,
  input  vrf_pkg::vrf_strb_t                             ldu_be_i,
  // Bank grants
  output logic [vrf_pkg::NrBanks-1:0]                    qa_bank_gnt_o,
  output logic [vrf_pkg::NrBanks-1:0]                    qb_bank_gnt_o,
  output logic [vrf_pkg::NrBanks-1:0]                    alu_bank_gnt_o,
  output logic [vrf_pkg::NrBanks-1:0]                    ldu_bank_gnt_o,
  // VRF banks
  output logic [vrf_pkg::NrBanks-1:0]                    vrf_req_o,
  output logic [vrf_pkg::NrBanks-1:0]                    vrf_wen_o,
  output logic [vrf_pkg::NrBanks-1:0][vrf_pkg::RowW-1:0] vrf_row_o,
  output vrf_pkg::vrf_word_t [vrf_pkg::NrBanks-1:0]      vrf_wdata_o,
  output vrf_pkg::vrf_strb_t [vrf_pkg::NrBanks-1:0]      vrf_be_o,
  output vrf_pkg::vrf_tgt_e  [vrf_pkg::NrBanks-1:0]      vrf_tgt_o
);

  import vrf_pkg::*;

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    logic hp_ptr_q;
    logic lp_ptr_q;
    logic hp_any;
    logic qa_g;
    logic alu_g;
    logic qb_g;
    logic ldu_g;

    assign hp_any = qa_bank_req_i[b] | alu_bank_req_i[b];

    // Pointer 0 favors queue A inside the high group
    assign qa_g  = qa_bank_req_i[b] & (!alu_bank_req_i[b] | !hp_ptr_q);
    assign alu_g = alu_bank_req_i[b] & (!qa_bank_req_i[b] | hp_ptr_q);

    // Low group only sees the bank when the high group is silent
    assign qb_g  = !hp_any & qb_bank_req_i[b] & (!ldu_bank_req_i[b] | !lp_ptr_q);
    assign ldu_g = !hp_any & ldu_bank_req_i[b] & (!qb_bank_req_i[b] | lp_ptr_q);

    assign qa_bank_gnt_o[b]  = qa_g;
    assign qb_bank_gnt_o[b]  = qb_g;
    assign alu_bank_gnt_o[b] = alu_g;
    assign ldu_bank_gnt_o[b] = ldu_g;

    // The bank accepts the winner in the same cycle
    assign vrf_req_o[b]   = qa_g | qb_g | alu_g | ldu_g;
    assign vrf_wen_o[b]   = alu_g | ldu_g;
    assign vrf_row_o[b]   = alu_g ? alu_row_i :
                            ldu_g ? ldu_row_i :
                            qb_g  ? qb_row_i  : qa_row_i;
    assign vrf_wdata_o[b] = alu_g ? alu_wdata_i :
                            ldu_g ? ldu_wdata_i : '0;
    assign vrf_be_o[b]    = alu_g ? alu_be_i :
                            ldu_g ? ldu_be_i : '0;
    assign vrf_tgt_o[b]   = qa_g ? TGT_QA :
                            qb_g ? TGT_QB : TGT_NONE;

    // Pointers move only after a contended grant in their group
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        hp_ptr_q <= 1'b0;
        lp_ptr_q <= 1'b0;
      end else begin
        if (qa_bank_req_i[b] && alu_bank_req_i[b]) begin
          hp_ptr_q <= !hp_ptr_q;
        end
        if (!hp_any && qb_bank_req_i[b] && ldu_bank_req_i[b]) begin
          lp_ptr_q <= !lp_ptr_q;
        end
      end
    end
  end : gen_bank

  // Each port carries one row, so it may win at most one bank per cycle
  a_one_bank_per_port: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(qa_bank_gnt_o) && $onehot0(qb_bank_gnt_o) &&
    $onehot0(alu_bank_gnt_o) && $onehot0(ldu_bank_gnt_o))
    else $error("a port was granted more than one bank in one cycle");

endmodule : vrf_arbiter

// ==== verilog/writeback_router.sv ====
//////////////////////////////////////////////////////////////////////
// Write-back router: ALU and load results to per-bank requests
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module writeback_router (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // ALU result port
  input  logic                        alu_req_i,
  input  vrf_pkg::vaddr_t             alu_addr_i,
  input  vrf_pkg::vrf_word_t          alu_wdata_i,
  input  vrf_pkg::vrf_strb_t          alu_be_i,
  output logic                        alu_gnt_o,
  // Load unit result port
  input  logic                        ldu_req_i,
  input  vrf_pkg::vaddr_t             ldu_addr_i,
  input  vrf_pkg::vrf_word_t          ldu_wdata_i,
  input  vrf_pkg::vrf_strb_t          ldu_be_i,
  output logic                        ldu_gnt_o,
  // Bank arbiter side
  output logic [vrf_pkg::NrBanks-1:0] alu_bank_req_o,
  output logic [vrf_pkg::NrBanks-1:0] ldu_bank_req_o,
  output logic [vrf_pkg::RowW-1:0]    alu_row_o,
  output logic [vrf_pkg::RowW-1:0]    ldu_row_o,
  output vrf_pkg::vrf_word_t          alu_wdata_o,
  output vrf_pkg::vrf_strb_t          alu_be_o,
  output vrf_pkg::vrf_word_t          ldu_wdata_o,
  output vrf_pkg::vrf_strb_t          ldu_be_o,
  input  logic [vrf_pkg::NrBanks-1:0] alu_bank_gnt_i,
  input  logic [vrf_pkg::NrBanks-1:0] ldu_bank_gnt_i
);

  import vrf_pkg::*;

  logic      ldu_full_q;
  vaddr_t    ldu_addr_q;
  vrf_word_t ldu_wdata_q;
  vrf_strb_t ldu_be_q;
  logic      ldu_drain;

  // One-hot bank select from the low address bits
  function automatic logic [NrBanks-1:0] bank_sel(vaddr_t addr);
    logic [NrBanks-1:0] sel;
    sel = '0;
    sel[addr.f.bank] = 1'b1;
    return sel;
  endfunction

  // ALU goes straight to the arbiter
  assign alu_bank_req_o = alu_req_i ? bank_sel(alu_addr_i) : '0;
  assign alu_row_o      = alu_addr_i.f.row;
  assign alu_wdata_o    = alu_wdata_i;
  assign alu_be_o       = alu_be_i;
  assign alu_gnt_o      = |alu_bank_gnt_i;

  ////////////////////////////////////////////////////////////////////
  // Load unit stream register
  ////////////////////////////////////////////////////////////////////

  assign ldu_drain = |ldu_bank_gnt_i;
  assign ldu_gnt_o = !ldu_full_q || ldu_drain;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ldu_full_q <= 1'b0;
    end else if (ldu_gnt_o) begin
      ldu_full_q <= ldu_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ldu_req_i && ldu_gnt_o) begin
      ldu_addr_q  <= ldu_addr_i;
      ldu_wdata_q <= ldu_wdata_i;
      ldu_be_q    <= ldu_be_i;
    end
  end

  assign ldu_bank_req_o = ldu_full_q ? bank_sel(ldu_addr_q) : '0;
  assign ldu_row_o      = ldu_addr_q.f.row;
  assign ldu_wdata_o    = ldu_wdata_q;
  assign ldu_be_o       = ldu_be_q;

  // A waiting ALU result keeps its address until a bank takes it
  a_alu_addr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (alu_req_i && !alu_gnt_o) |=> $stable(alu_addr_i))
    else $error("ALU write-back address changed before grant");

endmodule : writeback_router

// ==== verilog/operand_fetch.sv ====
//////////////////////////////////////////////////////////////////////
// Operand fetcher: walks one vector operand through the VRF,
// one 64-bit word per granted bank request
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module operand_fetch #(
  parameter int unsigned VLEN = 256
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Request from the sequencer
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  opreq_pkg::vreg_idx_t        req_vs_i,
  input  opreq_pkg::vlen_t            req_vstart_i,
  input  opreq_pkg::vlen_t            req_vl_i,
  input  opreq_pkg::eew_e             req_eew_i,
  // Operand queue side
  input  logic                        queue_ready_i,
  output logic                        issued_o,
  // Bank arbiter side
  output logic [vrf_pkg::NrBanks-1:0] bank_req_o,
  output logic [vrf_pkg::RowW-1:0]    bank_row_o,
  input  logic [vrf_pkg::NrBanks-1:0] bank_gnt_i
);

  import vrf_pkg::*;
  import opreq_pkg::*;

  localparam int unsigned WordsPerReg = VLEN / 64;
  localparam int unsigned AddrW       = RowW + BankIdxW;

  typedef enum logic {
    IDLE,
    REQUESTING
  } state_e;

  state_e     state_d, state_q;
  vaddr_t     addr_d, addr_q;
  vlen_t      len_d, len_q;
  eew_e       eew_d, eew_q;

  logic [3:0]       epw_q;
  logic [AddrW-1:0] req_word;
  vlen_t            req_len;
  logic             granted;
  logic             last_word;
  logic             accept;

  // Start word and remaining elements of an incoming request
  assign req_len  = (req_vl_i > req_vstart_i) ? req_vl_i - req_vstart_i : '0;
  assign req_word = AddrW'(req_vs_i * WordsPerReg)
                  + AddrW'(req_vstart_i >> (2'd3 - 2'(req_eew_i)));

  // Elements packed in one 64-bit word
  assign epw_q     = 4'b1000 >> eew_q;
  assign granted   = |bank_gnt_i;
  assign last_word = len_q <= vlen_t'(epw_q);

  // Free when idle, or when the last word is being granted
  assign req_ready_o = (state_q == IDLE) || (granted && last_word);
  assign accept      = req_valid_i && req_ready_o;

  always_comb begin
    bank_req_o = '0;
    if (state_q == REQUESTING && queue_ready_i) begin
      bank_req_o[addr_q.f.bank] = 1'b1;
    end
  end

  assign bank_row_o = addr_q.f.row;
  assign issued_o   = granted;

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    len_d   = len_q;
    eew_d   = eew_q;

    if (granted) begin
      addr_d.word = addr_q.word + 1'b1;
      len_d       = last_word ? '0 : len_q - vlen_t'(epw_q);
      if (last_word) begin
        state_d = IDLE;
      end
    end

    // Back-to-back operands take over in the cycle of the last grant
    if (accept) begin
      addr_d.word = req_word;
      len_d       = req_len;
      eew_d       = req_eew_i;
      state_d     = (req_len != '0) ? REQUESTING : IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      addr_q  <= '0;
      len_q   <= '0;
      eew_q   <= EW8;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      len_q   <= len_d;
      eew_q   <= eew_d;
    end
  end

  // The bank arbiter never grants a fetcher that has nothing to read
  a_no_gnt_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == IDLE) |-> (bank_gnt_i == '0))
    else $error("bank grant while the fetcher is idle");

endmodule : operand_fetch

// ==== verilog/opreq_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Operand request types: element width, register index, lengths
//////////////////////////////////////////////////////////////////////

package opreq_pkg;

  // Largest supported register length in bits
  localparam int unsigned MaxVLEN = 512;

  // Encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  typedef logic [4:0] vreg_idx_t;

  // Holds vl or vstart, up to MaxVLEN byte elements
  typedef logic [$clog2(MaxVLEN+1)-1:0] vlen_t;

endpackage : opreq_pkg

// ==== verilog/vrf_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Vector register file geometry, data word types and the word address
// that is read either flat or split into row and bank
//////////////////////////////////////////////////////////////////////

package vrf_pkg;

  // Consecutive word addresses interleave across the banks
  localparam int unsigned NrBanks  = 4;
  localparam int unsigned BankIdxW = 2;
  localparam int unsigned RowW     = 8;

  typedef logic [63:0] vrf_word_t;
  typedef logic [7:0]  vrf_strb_t;

  typedef struct packed {
    logic [RowW-1:0]     row;
    logic [BankIdxW-1:0] bank;
  } vaddr_fields_t;

  // One word address, two views of it
  typedef union packed {
    logic [RowW+BankIdxW-1:0] word;
    vaddr_fields_t            f;
  } vaddr_t;

  // Operand queue that receives a read beat
  typedef enum logic [1:0] {
    TGT_NONE = 2'd0,
    TGT_QA   = 2'd1,
    TGT_QB   = 2'd2
  } vrf_tgt_e;

endpackage : vrf_pkg
